// File: dcache_params.svh
// ====================
// Size constants for the data cache tag directory
// Way count must stay a power of two so that way numbers wrap in 2's complement
// Address split is tag | index | offset, with the tag taking what is left
// ====================
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Full byte address presented on lookup and fill
`define DC_ADDR_W 32

// 32-byte lines
`define DC_OFS_W 5

// Sets and ways of the directory
`define DC_SETS 64
`define DC_WAYS 4

// Widths derived from the counts above
`define DC_IDX_W ($clog2(`DC_SETS))
`define DC_WAY_W ($clog2(`DC_WAYS))
`define DC_TAG_W (`DC_ADDR_W - `DC_IDX_W - `DC_OFS_W)

`endif

// File: dcache_pkg.sv
// ====================
// Types shared by the tag directory blocks and the testbench
// Widths come from the macros of the params header
// ====================
`include "dcache_params.svh"

package dcache_pkg;

  // Scalar fields of an address and a way number
  typedef logic [`DC_TAG_W-1:0] dc_tag_t;
  typedef logic [`DC_IDX_W-1:0] dc_idx_t;
  typedef logic [`DC_WAY_W-1:0] dc_way_t;

  // Byte address as the cache sees it, tag in the top bits
  typedef struct packed {
    dc_tag_t                 tag;
    dc_idx_t                 index;
    logic [`DC_OFS_W-1:0]    offset;
  } dc_addr_t;

  // One set read out of the tag store
  // Entry w of tag pairs with bit w of valid
  typedef struct packed {
    dc_tag_t [`DC_WAYS-1:0]  tag;
    logic [`DC_WAYS-1:0]     valid;
  } dc_set_t;

  // Lookup result, way is the lowest hitting way or the last one seen
  typedef struct packed {
    logic                    hit;
    dc_way_t                 way;
  } dc_rsp_t;

  // Configuration that steers lookup and replacement
  typedef struct packed {
    logic [`DC_WAYS-1:0]     way_en;
  } dc_cfg_t;

endpackage

// File: dcache_cfg_regs.sv
// ====================
// Configuration registers of the tag directory
// Select 0 writes the way-enable mask, select 1 requests a flush
// Flush write data is ignored; flush writes must not come back to back
// ====================
`include "dcache_params.svh"

module dcache_cfg_regs
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cfg_we,
  input  logic                    cfg_sel,
  input  logic [`DC_WAYS-1:0]     cfg_wdata,
  output dcache_pkg::dc_cfg_t     cfg,
  output logic                    flush
);

  // ====================
  // Write decode
  // ====================

  // Mask write and flush request are the two register selects
  logic mask_wr;
  logic flush_wr;

  assign mask_wr  = cfg_we && !cfg_sel;
  assign flush_wr = cfg_we && cfg_sel;

  // ====================
  // Registers
  // ====================

  // All ways come out of reset enabled
  // A mask write shows on cfg from the next cycle on
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cfg.way_en <= '1;
    end
    else if (mask_wr)
    begin
      cfg.way_en <= cfg_wdata;
    end
  end

  // The flush request is registered into a one-cycle pulse
  // The tag store clears its valid bits on the edge after the pulse
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      flush <= 1'b0;
    end
    else
    begin
      flush <= flush_wr;
    end
  end

  // A stuck flush would keep the directory empty and hide every fill
  a_flush_pulse : assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
    else $error("flush held high for more than one cycle");

endmodule

// File: dcache_tag_store.sv
// ====================
// Tag and valid storage of the 4-way directory
// Two combinational set reads, one for lookup and one for fill
// Tags have no reset, only the valid bits are cleared
// Fill and flush in the same cycle is not supported
// ====================
`include "dcache_params.svh"

module dcache_tag_store
(
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_pkg::dc_idx_t     lookup_index,
  input  dcache_pkg::dc_idx_t     fill_index,
  input  logic                    fill,
  input  dcache_pkg::dc_tag_t     fill_tag,
  input  dcache_pkg::dc_way_t     fill_sel_way,
  input  logic                    flush,
  output dcache_pkg::dc_set_t     set_view,
  output dcache_pkg::dc_set_t     fill_view
);

  // ====================
  // Storage
  // ====================

  // One tag array per way, indexed by set
  dcache_pkg::dc_tag_t tag_mem [`DC_WAYS][`DC_SETS];

  // One valid vector per way, bit n belongs to set n
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;

  // Tag write on fill
  // The valid bit in the block below makes the entry visible
  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      tag_mem[fill_sel_way][fill_index] <= fill_tag;
    end
  end

  // Valid bits start clear and are cleared again by a flush
  // A fill marks the chosen way of its set
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (flush)
    begin
      valid_q <= '0;
    end
    else if (fill)
    begin
      valid_q[fill_sel_way][fill_index] <= 1'b1;
    end
  end

  // ====================
  // Set reads
  // ====================

  // Both views read the arrays before any write of this cycle lands,
  // so a lookup sees the old contents when a fill happens alongside
  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      set_view.tag[w]    = tag_mem[w][lookup_index];
      set_view.valid[w]  = valid_q[w][lookup_index];
      fill_view.tag[w]   = tag_mem[w][fill_index];
      fill_view.valid[w] = valid_q[w][fill_index];
    end
  end

  // The flush comes from the register block and the fill from outside;
  // a collision would drop the fill's valid bit silently
  a_no_fill_on_flush : assert property (@(posedge clk) disable iff (rst) !(fill && flush))
    else $error("fill and flush in the same cycle");

endmodule

// File: dcache_hit.sv
// ====================
// Hit detection over the four ways of the looked-up set
// Result is registered, one cycle after the lookup strobe
// On a miss the way field keeps the way of the previous response
// ====================
`include "dcache_params.svh"

module dcache_hit
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    lookup,
  input  dcache_pkg::dc_tag_t     tag,
  input  dcache_pkg::dc_set_t     set_view,
  input  dcache_pkg::dc_cfg_t     cfg,
  output dcache_pkg::dc_rsp_t     rsp,
  output logic                    rsp_valid
);

  // Per-way match and the lowest matching way
  logic [`DC_WAYS-1:0]    hits;
  dcache_pkg::dc_way_t    hit_way;

  // A way hits only if its tag matches, its entry is valid and it is enabled
  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      hits[w] = (set_view.tag[w] == tag) && set_view.valid[w] && cfg.way_en[w];
    end
  end

  // Lowest way wins, scanning down so the last assignment is the smallest
  always_comb
  begin
    hit_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      if (hits[w])
      begin
        hit_way = dcache_pkg::dc_way_t'(w);
      end
    end
  end

  // Response register, only touched on a lookup
  // A miss leaves the way field as it was
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rsp       <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= lookup;
      if (lookup)
      begin
        rsp.hit <= |hits;
        if (|hits)
        begin
          rsp.way <= hit_way;
        end
      end
    end
  end

  // Two ways holding one tag means a fill of a present line slipped through
  a_single_hit : assert property (@(posedge clk) disable iff (rst) lookup |-> $onehot0(hits))
    else $error("more than one way hit in a lookup");

endmodule

// File: dcache_repl.sv
// ====================
// Fill way selection for the 4-way directory
// First enabled invalid way, else round-robin over enabled ways
// Pointer moves only when a valid line is evicted
// At least one way must be enabled while filling
// ====================
`include "dcache_params.svh"

module dcache_repl
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fill,
  input  dcache_pkg::dc_set_t     fill_view,
  input  dcache_pkg::dc_cfg_t     cfg,
  output dcache_pkg::dc_way_t     fill_sel_way,
  output logic                    fill_done,
  output dcache_pkg::dc_way_t     fill_way
);

  // Enabled ways that hold nothing in the fill set
  logic [`DC_WAYS-1:0]    free_mask;
  logic                   free_any;
  dcache_pkg::dc_way_t    free_way;
  // Round-robin state and its candidate walk
  dcache_pkg::dc_way_t    rr_ptr;
  dcache_pkg::dc_way_t    rr_way;
  dcache_pkg::dc_way_t    rr_cand;

  assign free_mask = cfg.way_en & ~fill_view.valid;
  assign free_any  = |free_mask;

  // ====================
  // Way choice
  // ====================
  always_comb
  begin
    free_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      if (free_mask[w])
      begin
        free_way = dcache_pkg::dc_way_t'(w);
      end
    end
    // Walk from the pointer upward with wrap; the smallest offset is taken last
    rr_way  = rr_ptr;
    rr_cand = rr_ptr;
    for (int k = `DC_WAYS - 1; k >= 0; k--)
    begin
      rr_cand = rr_ptr + dcache_pkg::dc_way_t'(k);
      if (cfg.way_en[rr_cand])
      begin
        rr_way = rr_cand;
      end
    end
  end

  assign fill_sel_way = free_any ? free_way : rr_way;

  // Pointer steps past the victim, so the next eviction starts one way on
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rr_ptr    <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= fill;
      if (fill && !free_any)
      begin
        rr_ptr <= rr_way + 1'b1;
      end
    end
  end

  // Reported way is payload, qualified by fill_done
  always_ff @(posedge clk)
  begin
    if (fill)
    begin
      fill_way <= fill_sel_way;
    end
  end

  // With no way enabled the walk falls back to the pointer and would fill a disabled way
  a_fill_needs_way : assert property (@(posedge clk) disable iff (rst) fill |-> |cfg.way_en)
    else $error("fill with every way disabled");

endmodule

// File: dcache_tag_top.sv
// ====================
// Tag side of a 4-way set-associative data cache
// Single-cycle strobes for lookup, fill and register write, no back-pressure
// Caller must not fill a line that is present or fill with all ways disabled
// ====================
`include "dcache_params.svh"

module dcache_tag_top
(
  input  logic                    clk,
  input  logic                    rst,
  // Lookup
  input  logic                    lookup,
  input  dcache_pkg::dc_addr_t    lookup_adr,
  output dcache_pkg::dc_rsp_t     rsp,
  output logic                    rsp_valid,
  // Fill
  input  logic                    fill,
  input  dcache_pkg::dc_addr_t    fill_adr,
  output logic                    fill_done,
  output dcache_pkg::dc_way_t     fill_way,
  // Register write
  input  logic                    cfg_we,
  input  logic                    cfg_sel,
  input  logic [`DC_WAYS-1:0]     cfg_wdata
);

  // Configuration and the flush pulse from the register block
  dcache_pkg::dc_cfg_t    cfg;
  logic                   flush;
  // Set views for the lookup and fill indexes
  dcache_pkg::dc_set_t    set_view;
  dcache_pkg::dc_set_t    fill_view;
  // Way chosen for the current fill
  dcache_pkg::dc_way_t    fill_sel_way;

  dcache_cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg),
    .flush     (flush)
  );

  dcache_tag_store u_tag_store (
    .clk          (clk),
    .rst          (rst),
    .lookup_index (lookup_adr.index),
    .fill_index   (fill_adr.index),
    .fill         (fill),
    .fill_tag     (fill_adr.tag),
    .fill_sel_way (fill_sel_way),
    .flush        (flush),
    .set_view     (set_view),
    .fill_view    (fill_view)
  );

  dcache_hit u_hit (
    .clk       (clk),
    .rst       (rst),
    .lookup    (lookup),
    .tag       (lookup_adr.tag),
    .set_view  (set_view),
    .cfg       (cfg),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

  dcache_repl u_repl (
    .clk          (clk),
    .rst          (rst),
    .fill         (fill),
    .fill_view    (fill_view),
    .cfg          (cfg),
    .fill_sel_way (fill_sel_way),
    .fill_done    (fill_done),
    .fill_way     (fill_way)
  );

endmodule

// File: tb_dcache_tag.sv
// ====================
// Testbench for the tag directory top level
// Operations and expected results come from dcache_stimulus.txt, four words per line
// Up to 64 operations; an op code of 0 ends the list
// ====================
`include "dcache_params.svh"

module tb_dcache_tag;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_OPS   = 64;
  localparam int OP_LOOKUP = 1;
  localparam int OP_FILL   = 2;
  localparam int OP_WRITE  = 3;

  logic                    clk;
  logic                    rst;
  logic                    lookup;
  dcache_pkg::dc_addr_t    lookup_adr;
  dcache_pkg::dc_rsp_t     rsp;
  logic                    rsp_valid;
  logic                    fill;
  dcache_pkg::dc_addr_t    fill_adr;
  logic                    fill_done;
  dcache_pkg::dc_way_t     fill_way;
  logic                    cfg_we;
  logic                    cfg_sel;
  logic [`DC_WAYS-1:0]     cfg_wdata;

  // Flat copy of the stimulus file, entry 4k is the op code of line k
  logic [31:0] stim [0:4*MAX_OPS-1];
  int n_ops;
  int n_pass;
  int n_fail;
  int cycles;
  int cycle_limit = 0;

  dcache_tag_top UUT (
    .clk        (clk),
    .rst        (rst),
    .lookup     (lookup),
    .lookup_adr (lookup_adr),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid),
    .fill       (fill),
    .fill_adr   (fill_adr),
    .fill_done  (fill_done),
    .fill_way   (fill_way),
    .cfg_we     (cfg_we),
    .cfg_sel    (cfg_sel),
    .cfg_wdata  (cfg_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // Watchdog
  // ====================
  // The limit is set once the stimulus is loaded, at ten cycles per operation plus margin
  initial
  begin
    cycles = 0;
    while (cycle_limit == 0 || cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing the operation list", cycles);
    $display("TEST FAIL");
    $finish;
  end

  // Runs line k of the stimulus and checks its result
  // Called 1 ns after a rising edge, and returns at the same point of a later cycle
  task automatic run_op(input int k);
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] expect_val;
    string       name;
    op         = stim[4*k];
    a          = stim[4*k+1];
    d          = stim[4*k+2];
    expect_val = stim[4*k+3];
    if (op == OP_LOOKUP)
    begin
      name       = $sformatf("test %0d lookup %08h", k + 1, a);
      lookup_adr = a;
      lookup     = 1'b1;
      @(posedge clk);
      #1;
      lookup = 1'b0;
      // The response register loads on the edge that sampled the strobe
      if (!rsp_valid)
      begin
        $display("%s: no valid response one cycle after the lookup", name);
        n_fail++;
      end
      else if ({rsp.hit, rsp.way} != expect_val[2:0])
      begin
        $display("[ERROR] %s expected hit=%0d way=%0d actual hit=%0d way=%0d", name,
                 expect_val[2], expect_val[1:0], rsp.hit, rsp.way);
        n_fail++;
      end
      else
      begin
        $display("%s ok, hit=%0d way=%0d", name, rsp.hit, rsp.way);
        n_pass++;
      end
    end
    else if (op == OP_FILL)
    begin
      name     = $sformatf("test %0d fill %08h", k + 1, a);
      fill_adr = a;
      fill     = 1'b1;
      @(posedge clk);
      #1;
      fill = 1'b0;
      // Tag, valid bit and the done pulse all land on the sampling edge
      if (!fill_done)
      begin
        $display("%s: fill_done did not pulse one cycle after the fill", name);
        n_fail++;
      end
      else if (fill_way != expect_val[`DC_WAY_W-1:0])
      begin
        $display("[ERROR] %s expected way=%0d actual way=%0d", name,
                 expect_val[`DC_WAY_W-1:0], fill_way);
        n_fail++;
      end
      else
      begin
        $display("%s ok, way=%0d", name, fill_way);
        n_pass++;
      end
    end
    else if (op == OP_WRITE)
    begin
      name      = $sformatf("test %0d reg write sel=%0d data=%0h", k + 1, a[0], d[3:0]);
      cfg_sel   = a[0];
      cfg_wdata = d[`DC_WAYS-1:0];
      cfg_we    = 1'b1;
      @(posedge clk);
      #1;
      cfg_we = 1'b0;
      // A flush pulses one cycle later and clears valid bits on the edge after
      repeat (2) @(posedge clk);
      #1;
      // No lookup or fill went in during the write, so both result strobes are low
      if (rsp_valid || fill_done)
      begin
        $display("%s: a result strobe stayed high with no lookup or fill in flight", name);
        n_fail++;
      end
      else
      begin
        $display("%s applied, result strobes idle", name);
        n_pass++;
      end
    end
    else
    begin
      $display("test %0d: unknown operation code %0h in the stimulus file", k + 1, op);
      n_fail++;
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial
  begin
    rst        = 1'b1;
    lookup     = 1'b0;
    lookup_adr = '0;
    fill       = 1'b0;
    fill_adr   = '0;
    cfg_we     = 1'b0;
    cfg_sel    = 1'b0;
    cfg_wdata  = '0;
    n_pass     = 0;
    n_fail     = 0;
    for (int i = 0; i < 4 * MAX_OPS; i++)
    begin
      stim[i] = '0;
    end
    $readmemh("dcache_stimulus.txt", stim);
    n_ops = 0;
    while (n_ops < MAX_OPS && stim[4*n_ops] != 0)
    begin
      n_ops++;
    end
    if (n_ops == 0)
    begin
      $display("The stimulus file is missing or holds no operations");
      n_fail++;
    end
    cycle_limit = 10 * n_ops + 50;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int k = 0; k < n_ops; k++)
    begin
      run_op(k);
    end

    $display("Checks finished: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
dcache_pkg.sv
dcache_cfg_regs.sv
dcache_tag_store.sv
dcache_hit.sv
dcache_repl.sv
dcache_tag_top.sv
tb_dcache_tag.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_dcache_tag
FLIST    := flist.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS     := $(wildcard *.svh)
STIM     := dcache_stimulus.txt

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN) $(STIM)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dcache_stimulus.txt
// op (1 lookup, 2 fill, 3 reg write)  address or reg select  write data  expected
// Lookup expected is hit*4 + way, fill expected is the fill way, reg write expected unused
1 00000860 0 0
1 12345678 0 0
// Set 3 fills into empty ways, then hits and a miss
2 00000860 0 0
2 00001060 0 1
2 00001860 0 2
2 00002060 0 3
1 00000860 0 4
1 00001060 0 5
1 00001860 0 6
1 00002060 0 7
1 00002860 0 3
// Evictions by round-robin
2 00002860 0 0
1 00000860 0 3
1 00002860 0 4
2 00003060 0 1
1 00001060 0 0
1 00003060 0 5
// Disable way 2
3 00000000 b 0
1 00001860 0 1
1 00002060 0 7
2 00003860 0 3
1 00002060 0 3
1 00003860 0 7
2 000008a0 0 0
2 000010a0 0 1
2 000018a0 0 3
2 000020a0 0 0
1 000020a0 0 4
1 000018a0 0 7
// Flush
3 00000001 0 0
1 00002860 0 3
1 00003860 0 3
1 000018a0 0 3
2 00004060 0 0
2 000008a0 0 0
1 00004060 0 4
